// ==== include/rv32_opcodes.svh ====
/*
  RV32 opcode, funct and instruction match patterns.
  Included by the decoder and by the testbench decode model.
  Full-word patterns hold ? bits and are meant for ==? and casez.
*/
`ifndef RV32_OPCODES_SVH
`define RV32_OPCODES_SVH

// Major opcodes, bits [6:0]
`define RV32_LUI_OP     7'b0110111
`define RV32_AUIPC_OP   7'b0010111
`define RV32_JAL_OP     7'b1101111
`define RV32_JALR_OP    7'b1100111
`define RV32_BRANCH     7'b1100011
`define RV32_LOAD       7'b0000011
`define RV32_STORE      7'b0100011
`define RV32_OP_IMM     7'b0010011
`define RV32_OP         7'b0110011
`define RV32_MISC_MEM   7'b0001111
`define RV32_SYSTEM     7'b1110011
`define RV32_AMO_OP     7'b0101111

// funct7 of base register-register ops
`define RV32_FUNCT7_BASE 7'b0000000
`define RV32_FUNCT7_ALT  7'b0100000

// CSR funct3
`define RV32_CSRRW_FUN3  3'b001
`define RV32_CSRRS_FUN3  3'b010
`define RV32_CSRRC_FUN3  3'b011
`define RV32_CSRRWI_FUN3 3'b101
`define RV32_CSRRSI_FUN3 3'b110
`define RV32_CSRRCI_FUN3 3'b111

// Fence mode field [31:28] picks fence or barrier
`define RV32_FENCE_OP   32'b????_????_????_?????_000_?????_0001111
`define RV32_FENCE_FM   4'b0000
`define RV32_BARSEND_FM 4'b0001
`define RV32_BARRECV_FM 4'b0010

`define RV32_MRET       32'b0011000_00010_00000_000_00000_1110011

// M extension
`define RV32_MUL        32'b0000001_?????_?????_000_?????_0110011
`define RV32_MULH       32'b0000001_?????_?????_001_?????_0110011
`define RV32_MULHSU     32'b0000001_?????_?????_010_?????_0110011
`define RV32_MULHU      32'b0000001_?????_?????_011_?????_0110011
`define RV32_DIV        32'b0000001_?????_?????_100_?????_0110011
`define RV32_DIVU       32'b0000001_?????_?????_101_?????_0110011
`define RV32_REM        32'b0000001_?????_?????_110_?????_0110011
`define RV32_REMU       32'b0000001_?????_?????_111_?????_0110011

// A extension subset, aq/rl in bits 26:25
`define RV32_LR_W       32'b00010_??_00000_?????_010_?????_0101111
`define RV32_AMOSWAP_W  32'b00001_??_?????_?????_010_?????_0101111
`define RV32_AMOOR_W    32'b01000_??_?????_?????_010_?????_0101111
`define RV32_AMOADD_W   32'b00000_??_?????_?????_010_?????_0101111

`endif

// ==== logic/cl_decode.sv ====
/*
  Combinational instruction decoder.
  Turns one RV32 word into decode_s: register use, load/store width,
  instruction class and M/A sub-operations. MULH, MULHSU and MULHU
  are flagged unsupported. Words that match nothing give class none.
*/
`timescale 1ns/1ps
`include "rv32_opcodes.svh"

module cl_decode
  import vanilla_decode_pkg::*;
(
  input  instr_t  instruction_i,
  output decode_s decode_o
);

  logic [6:0] op;
  logic [4:0] rd;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       write_rd;
  logic       read_rs1;
  logic       read_rs2;
  logic       is_load;
  logic       is_store;
  logic       is_amo_rmw;
  logic       unsupported;
  op_class_e  op_class;
  idiv_op_e   idiv_op;
  amo_type_e  amo_type;

  assign op     = instruction_i[6:0];
  assign rd     = instruction_i[11:7];
  assign funct3 = instruction_i[14:12];
  assign funct7 = instruction_i[31:25];

  // Swap, or and add read rs2, LR does not
  assign is_amo_rmw = (op == `RV32_AMO_OP) &
                      ((funct7[6:2] == 5'b00001) | (funct7[6:2] == 5'b01000) |
                       (funct7[6:2] == 5'b00000));

  // x0 is never written
  always_comb begin
    if (rd == 5'd0) begin
      write_rd = 1'b0;
    end else begin
      unique case (op)
        `RV32_LUI_OP, `RV32_AUIPC_OP, `RV32_JAL_OP, `RV32_JALR_OP,
        `RV32_LOAD, `RV32_OP, `RV32_OP_IMM, `RV32_AMO_OP, `RV32_SYSTEM: write_rd = 1'b1;
        default: write_rd = 1'b0;
      endcase
    end
  end

  always_comb begin
    unique case (op)
      `RV32_JALR_OP, `RV32_BRANCH, `RV32_LOAD, `RV32_STORE,
      `RV32_OP, `RV32_OP_IMM, `RV32_AMO_OP: read_rs1 = 1'b1;
      // Only register forms of CSR access
      `RV32_SYSTEM: read_rs1 = (funct3 == `RV32_CSRRW_FUN3) | (funct3 == `RV32_CSRRS_FUN3) |
                               (funct3 == `RV32_CSRRC_FUN3);
      default: read_rs1 = 1'b0;
    endcase
  end

  assign read_rs2 = (op == `RV32_BRANCH) | (op == `RV32_STORE) | (op == `RV32_OP) | is_amo_rmw;

  assign is_load  = (op == `RV32_LOAD);
  assign is_store = (op == `RV32_STORE);

  // Class and sub-operation
  always_comb begin
    op_class    = e_op_none;
    idiv_op     = eDIV;
    amo_type    = e_amo_swap;
    unsupported = 1'b0;
    unique case (op)
      `RV32_LUI_OP, `RV32_AUIPC_OP, `RV32_OP_IMM: op_class = e_op_alu;
      `RV32_LOAD:    op_class = e_op_load;
      `RV32_STORE:   op_class = e_op_store;
      `RV32_BRANCH:  op_class = e_op_branch;
      `RV32_JAL_OP:  op_class = e_op_jal;
      `RV32_JALR_OP: op_class = e_op_jalr;
      `RV32_OP: begin
        if (funct7 == `RV32_FUNCT7_BASE) begin
          op_class = e_op_alu;
        end else if (funct7 == `RV32_FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          // SUB and SRA
          op_class = e_op_alu;
        end else begin
          unique casez (instruction_i)
            `RV32_MUL:  op_class = e_op_mul;
            `RV32_MULH, `RV32_MULHSU, `RV32_MULHU: unsupported = 1'b1;
            `RV32_DIV: begin
              op_class = e_op_div;
              idiv_op  = eDIV;
            end
            `RV32_DIVU: begin
              op_class = e_op_div;
              idiv_op  = eDIVU;
            end
            `RV32_REM: begin
              op_class = e_op_div;
              idiv_op  = eREM;
            end
            `RV32_REMU: begin
              op_class = e_op_div;
              idiv_op  = eREMU;
            end
            default: op_class = e_op_none;
          endcase
        end
      end
      `RV32_MISC_MEM: begin
        if (instruction_i ==? `RV32_FENCE_OP) begin
          unique case (instruction_i[31:28])
            `RV32_FENCE_FM:   op_class = e_op_fence;
            `RV32_BARSEND_FM: op_class = e_op_barsend;
            `RV32_BARRECV_FM: op_class = e_op_barrecv;
            default:          op_class = e_op_none;
          endcase
        end
      end
      `RV32_SYSTEM: begin
        if (instruction_i == `RV32_MRET) begin
          op_class = e_op_mret;
        end else if (funct3 != 3'b000 && funct3 != 3'b100) begin
          op_class = e_op_csr;
        end
      end
      `RV32_AMO_OP: begin
        unique casez (instruction_i)
          `RV32_LR_W: op_class = e_op_lr;
          `RV32_AMOSWAP_W: begin
            op_class = e_op_amo;
            amo_type = e_amo_swap;
          end
          `RV32_AMOOR_W: begin
            op_class = e_op_amo;
            amo_type = e_amo_or;
          end
          `RV32_AMOADD_W: begin
            op_class = e_op_amo;
            amo_type = e_amo_add;
          end
          default: op_class = e_op_none;
        endcase
      end
      default: op_class = e_op_none;
    endcase
  end

  always_comb begin
    decode_o.write_rd         = write_rd;
    decode_o.read_rs1         = read_rs1;
    decode_o.read_rs2         = read_rs2;
    decode_o.is_load_op       = is_load;
    decode_o.is_store_op      = is_store;
    decode_o.is_byte_op       = (is_load & (funct3 ==? 3'b?00)) | (is_store & (funct3 == 3'b000));
    decode_o.is_hex_op        = (is_load & (funct3 ==? 3'b?01)) | (is_store & (funct3 == 3'b001));
    decode_o.is_load_unsigned = is_load & (funct3 ==? 3'b10?);
    decode_o.op_class         = op_class;
    decode_o.idiv_op          = idiv_op;
    decode_o.amo_type         = amo_type;
    decode_o.is_amo_aq        = (op == `RV32_AMO_OP) & instruction_i[26];
    decode_o.is_amo_rl        = (op == `RV32_AMO_OP) & instruction_i[25];
    decode_o.unsupported      = unsupported;
  end

endmodule

// ==== logic/fetch_unit.sv ====
/*
  Fetch unit of one hart.
  Walks its own memory region word by word, one fetch in flight at a
  time, and only while a consumer credit is left. Each returned word
  is decoded and registered to the consumer outputs with its PC.
*/
`timescale 1ns/1ps

module fetch_unit
  import vanilla_decode_pkg::*;
#(
  parameter int HART_ID   = 0,
  parameter int NUM_HARTS = 2,
  parameter int ADDR_W    = IMEM_AW,
  parameter int CREDITS   = 4
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      run_i,
  imem_if.fetch     mem,
  input  logic      credit_i,
  output logic      dec_valid_o,
  output pc_t       dec_pc_o,
  output instr_t    dec_instr_o,
  output op_class_e dec_class_o,
  output logic      dec_write_rd_o,
  output logic      dec_read_rs1_o,
  output logic      dec_read_rs2_o,
  output logic      dec_unsupported_o
);

  localparam int  REGION_W = ADDR_W - $clog2(NUM_HARTS);
  localparam int  CNT_W    = $clog2(CREDITS + 1);
  localparam pc_t BASE     = pc_t'(HART_ID) << REGION_W;

  pc_t                pc_q;
  pc_t                pc_next;
  logic               inflight_q;
  logic [CNT_W-1:0]   credits_q;
  logic [REGION_W-1:0] offset_next;
  decode_s            dec;

  cl_decode u_decode (
    .instruction_i(mem.rdata),
    .decode_o     (dec)
  );

  // Offset wraps inside the hart's region
  assign offset_next = pc_q[REGION_W-1:0] + 1'b1;
  assign pc_next     = BASE | pc_t'(offset_next);

  assign mem.req  = run_i && !inflight_q && (credits_q != '0);
  assign mem.addr = pc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q        <= BASE;
      inflight_q  <= 1'b0;
      credits_q   <= CNT_W'(CREDITS);
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= mem.rvalid;
      if (mem.gnt) begin
        inflight_q <= 1'b1;
      end else if (mem.rvalid) begin
        inflight_q <= 1'b0;
      end
      // Credit leaves with the output, comes back on credit_i
      credits_q <= credits_q - CNT_W'(mem.rvalid) + CNT_W'(credit_i);
      if (mem.rvalid) begin
        pc_q <= pc_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem.rvalid) begin
      dec_pc_o          <= pc_q;
      dec_instr_o       <= mem.rdata;
      dec_class_o       <= dec.op_class;
      dec_write_rd_o    <= dec.write_rd;
      dec_read_rs1_o    <= dec.read_rs1;
      dec_read_rs2_o    <= dec.read_rs2;
      dec_unsupported_o <= dec.unsupported;
    end
  end

endmodule

// ==== logic/frontend_top.sv ====
/*
  Instruction front end top level.
  Shared instruction memory and arbiter plus one fetch unit per hart.
  Load the memory with run_i low, then raise run_i and return one
  credit_i pulse per consumed dec_valid_o.
*/
`timescale 1ns/1ps

module frontend_top
  import vanilla_decode_pkg::*;
#(
  parameter int NUM_HARTS = 2,
  parameter int ADDR_W    = IMEM_AW,
  parameter int CREDITS   = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        run_i,
  input  logic                        ld_we_i,
  input  pc_t                         ld_addr_i,
  input  instr_t                      ld_data_i,
  input  logic      [NUM_HARTS-1:0]   credit_i,
  output logic      [NUM_HARTS-1:0]   dec_valid_o,
  output pc_t       [NUM_HARTS-1:0]   dec_pc_o,
  output instr_t    [NUM_HARTS-1:0]   dec_instr_o,
  output op_class_e [NUM_HARTS-1:0]   dec_class_o,
  output logic      [NUM_HARTS-1:0]   dec_write_rd_o,
  output logic      [NUM_HARTS-1:0]   dec_read_rs1_o,
  output logic      [NUM_HARTS-1:0]   dec_read_rs2_o,
  output logic      [NUM_HARTS-1:0]   dec_unsupported_o
);

  imem_if harts_if [NUM_HARTS] ();

  imem_arbiter #(
    .NUM_HARTS(NUM_HARTS),
    .ADDR_W   (ADDR_W)
  ) u_arbiter (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .run_i    (run_i),
    .ld_we_i  (ld_we_i),
    .ld_addr_i(ld_addr_i),
    .ld_data_i(ld_data_i),
    .harts    (harts_if)
  );

  for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
    fetch_unit #(
      .HART_ID  (h),
      .NUM_HARTS(NUM_HARTS),
      .ADDR_W   (ADDR_W),
      .CREDITS  (CREDITS)
    ) u_fetch (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .run_i            (run_i),
      .mem              (harts_if[h]),
      .credit_i         (credit_i[h]),
      .dec_valid_o      (dec_valid_o[h]),
      .dec_pc_o         (dec_pc_o[h]),
      .dec_instr_o      (dec_instr_o[h]),
      .dec_class_o      (dec_class_o[h]),
      .dec_write_rd_o   (dec_write_rd_o[h]),
      .dec_read_rs1_o   (dec_read_rs1_o[h]),
      .dec_read_rs2_o   (dec_read_rs2_o[h]),
      .dec_unsupported_o(dec_unsupported_o[h])
    );
  end

endmodule

// ==== logic/imem_arbiter.sv ====
/*
  Shared single-port instruction memory with a round-robin arbiter.
  One requesting hart is granted per cycle; its read data and rvalid
  come back one cycle after the grant. The load port writes the
  array only while run_i is low.
*/
`timescale 1ns/1ps

module imem_arbiter
  import vanilla_decode_pkg::*;
#(
  parameter int NUM_HARTS = 2,
  parameter int ADDR_W    = IMEM_AW
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   run_i,
  input  logic   ld_we_i,
  input  pc_t    ld_addr_i,
  input  instr_t ld_data_i,
  imem_if.mem    harts [NUM_HARTS]
);

  localparam int IDX_W = $clog2(NUM_HARTS);
  localparam int DEPTH = 2 ** ADDR_W;

  instr_t               mem_q [DEPTH];
  instr_t               rdata_q;
  pc_t                  addr_vec [NUM_HARTS];
  logic [NUM_HARTS-1:0] req_vec;
  logic [NUM_HARTS-1:0] gnt_vec;
  logic [NUM_HARTS-1:0] rvalid_q;
  logic [IDX_W-1:0]     last_q;
  logic [IDX_W-1:0]     gnt_idx;
  logic                 gnt_any;

  for (genvar h = 0; h < NUM_HARTS; h++) begin : g_port
    assign req_vec[h]      = harts[h].req;
    assign addr_vec[h]     = harts[h].addr;
    assign harts[h].gnt    = gnt_vec[h];
    assign harts[h].rvalid = rvalid_q[h];
    // Data is shared, rvalid picks the owner
    assign harts[h].rdata  = rdata_q;
  end

  // Search starts one past the last granted hart
  always_comb begin : p_grant
    logic [IDX_W-1:0] idx;
    gnt_any = 1'b0;
    gnt_idx = last_q;
    gnt_vec = '0;
    for (int i = 1; i <= NUM_HARTS; i++) begin
      idx = IDX_W'((int'(last_q) + i) % NUM_HARTS);
      if (!gnt_any && run_i && req_vec[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = idx;
      end
    end
    if (gnt_any) begin
      gnt_vec[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Hart 0 wins the first contended cycle
      last_q   <= IDX_W'(NUM_HARTS - 1);
      rvalid_q <= '0;
    end else begin
      rvalid_q <= gnt_vec;
      if (gnt_any) begin
        last_q <= gnt_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!run_i && ld_we_i) begin
      mem_q[ld_addr_i[ADDR_W-1:0]] <= ld_data_i;
    end
    if (gnt_any) begin
      rdata_q <= mem_q[addr_vec[gnt_idx][ADDR_W-1:0]];
    end
  end

endmodule

// ==== logic/imem_if.sv ====
/*
  Request and response bundle between one hart's fetch unit and
  the shared instruction memory. One instance per hart.
*/
`timescale 1ns/1ps

interface imem_if
  import vanilla_decode_pkg::*;
();

  logic   req;
  pc_t    addr;
  logic   gnt;
  instr_t rdata;
  logic   rvalid;

  // Requester holds req and addr until gnt
  modport fetch (output req, output addr, input gnt, input rdata, input rvalid);

  modport mem (input req, input addr, output gnt, output rdata, output rvalid);

endinterface

// ==== logic/vanilla_decode_pkg.sv ====
/*
  Shared types of the instruction front end.
  Holds the word and address widths, the instruction class and
  sub-operation encodings, and the packed decode result that the
  decoder produces and the fetch units register.
*/
package vanilla_decode_pkg;

  // Default word address width, 64 words
  localparam int IMEM_AW = 6;

  typedef logic [31:0]        instr_t;
  typedef logic [IMEM_AW-1:0] pc_t;

  // Instruction class as seen by the consumer
  typedef enum logic [3:0] {
    e_op_alu     = 4'd0,
    e_op_load    = 4'd1,
    e_op_store   = 4'd2,
    e_op_branch  = 4'd3,
    e_op_jal     = 4'd4,
    e_op_jalr    = 4'd5,
    e_op_csr     = 4'd6,
    e_op_fence   = 4'd7,
    e_op_barsend = 4'd8,
    e_op_barrecv = 4'd9,
    e_op_mul     = 4'd10,
    e_op_div     = 4'd11,
    e_op_lr      = 4'd12,
    e_op_amo     = 4'd13,
    e_op_mret    = 4'd14,
    e_op_none    = 4'd15
  } op_class_e;

  typedef enum logic [1:0] {
    eDIV  = 2'd0,
    eDIVU = 2'd1,
    eREM  = 2'd2,
    eREMU = 2'd3
  } idiv_op_e;

  typedef enum logic [1:0] {
    e_amo_swap = 2'd0,
    e_amo_or   = 2'd1,
    e_amo_add  = 2'd2
  } amo_type_e;

  typedef struct packed {
    logic      write_rd;
    logic      read_rs1;
    logic      read_rs2;
    logic      is_load_op;
    logic      is_store_op;
    logic      is_byte_op;
    logic      is_hex_op;
    logic      is_load_unsigned;
    op_class_e op_class;
    idiv_op_e  idiv_op;
    amo_type_e amo_type;
    logic      is_amo_aq;
    logic      is_amo_rl;
    logic      unsupported;
  } decode_s;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the front end testbench with Verilator, run it and check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend \
  -f verilog.f --Mdir obj_dir -o sim_frontend

./obj_dir/sim_frontend 2>&1 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb/frontend_asserts.sv ====
/*
  Concurrent checks on the arbiter handshake.
  Bound into imem_arbiter and watches the request, grant and read
  valid vectors of all harts.
*/
`timescale 1ns/1ps

module frontend_asserts #(
  parameter int NUM_HARTS = 2
) (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic [NUM_HARTS-1:0] req_i,
  input logic [NUM_HARTS-1:0] gnt_i,
  input logic [NUM_HARTS-1:0] rvalid_i
);

  // One grant per cycle at most
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt_i))
    else $error("more than one hart granted in one cycle");

  a_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_n_i) (gnt_i & ~req_i) == '0)
    else $error("grant given to a hart without a request");

  // Read data comes back one cycle after the grant
  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i) rvalid_i == $past(gnt_i))
    else $error("rvalid does not follow the grant by one cycle");

endmodule

// ==== tb/tb_frontend.sv ====
/*
  Testbench of the instruction front end.
  Loads both hart regions with a random instruction mix, then runs
  with random, withheld and immediate credit return. Every output is
  checked against a PC model and a decode model built on the opcodes.
*/
`timescale 1ns/1ps
`include "rv32_opcodes.svh"

module tb_frontend
  import vanilla_decode_pkg::*;
();

  localparam int NUM_HARTS    = 2;
  localparam int ADDR_W       = IMEM_AW;
  localparam int CREDITS      = 4;
  localparam int DEPTH        = 2 ** ADDR_W;
  localparam int REGION       = DEPTH / NUM_HARTS;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 37;
  localparam int A_WORDS      = 2 * REGION;
  localparam int C_WORDS      = REGION;
  localparam int STALL_CYCLES = 60;
  localparam int MAX_GAP      = 2 * NUM_HARTS + 2;
  localparam int WORST_CYC    = 20;
  localparam int LIMIT_CYCLES = RESET_CYCLES + DEPTH + STALL_CYCLES +
                                NUM_HARTS * (A_WORDS + C_WORDS) * WORST_CYC;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      run_i;
  logic                      ld_we_i;
  pc_t                       ld_addr_i;
  instr_t                    ld_data_i;
  logic      [NUM_HARTS-1:0] credit_i = '0;
  logic      [NUM_HARTS-1:0] dec_valid_o;
  pc_t       [NUM_HARTS-1:0] dec_pc_o;
  instr_t    [NUM_HARTS-1:0] dec_instr_o;
  op_class_e [NUM_HARTS-1:0] dec_class_o;
  logic      [NUM_HARTS-1:0] dec_write_rd_o;
  logic      [NUM_HARTS-1:0] dec_read_rs1_o;
  logic      [NUM_HARTS-1:0] dec_read_rs2_o;
  logic      [NUM_HARTS-1:0] dec_unsupported_o;

  // Model state
  instr_t exp_mem [DEPTH];
  pc_t    exp_pc [NUM_HARTS];
  int     outstanding [NUM_HARTS] = '{default: 0};
  int     out_count [NUM_HARTS] = '{default: 0};
  int     c_count [NUM_HARTS] = '{default: 0};
  int     gap [NUM_HARTS] = '{default: 0};
  int     cycle = 0;
  int     phase;
  int     checks;
  int     errors;

  frontend_top #(
    .NUM_HARTS(NUM_HARTS),
    .ADDR_W   (ADDR_W),
    .CREDITS  (CREDITS)
  ) frontend_top_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .run_i            (run_i),
    .ld_we_i          (ld_we_i),
    .ld_addr_i        (ld_addr_i),
    .ld_data_i        (ld_data_i),
    .credit_i         (credit_i),
    .dec_valid_o      (dec_valid_o),
    .dec_pc_o         (dec_pc_o),
    .dec_instr_o      (dec_instr_o),
    .dec_class_o      (dec_class_o),
    .dec_write_rd_o   (dec_write_rd_o),
    .dec_read_rs1_o   (dec_read_rs1_o),
    .dec_read_rs2_o   (dec_read_rs2_o),
    .dec_unsupported_o(dec_unsupported_o)
  );

  bind imem_arbiter frontend_asserts #(.NUM_HARTS(NUM_HARTS)) u_asserts (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_vec),
    .gnt_i   (gnt_vec),
    .rvalid_i(rvalid_q)
  );

  // Weighted mix over all classes, M words incl. MULH types, and junk
  function automatic instr_t random_word();
    instr_t w;
    w = $urandom();
    case ($urandom_range(0, 19))
      0: w = {w[31:7], `RV32_LUI_OP};
      1: w = {w[31:7], `RV32_AUIPC_OP};
      2: w = {w[31:7], `RV32_OP_IMM};
      3: w = {`RV32_FUNCT7_BASE, w[24:7], `RV32_OP};
      4: w = {`RV32_FUNCT7_ALT, w[24:15], w[12] ? 3'b101 : 3'b000, w[11:7], `RV32_OP};
      5, 6: w = {7'b0000001, w[24:7], `RV32_OP};
      7: w = {w[31:7], `RV32_LOAD};
      8: w = {w[31:7], `RV32_STORE};
      9: w = {w[31:7], `RV32_BRANCH};
      10: w = {w[31:7], `RV32_JAL_OP};
      11: w = {w[31:7], `RV32_JALR_OP};
      12: w = {w[31:7], `RV32_SYSTEM};
      13: w = `RV32_MRET;
      14: w = {2'b00, w[29:15], 3'b000, w[11:7], `RV32_MISC_MEM};
      15: w = {5'b00010, w[26:25], 5'd0, w[19:15], 3'b010, w[11:7], `RV32_AMO_OP};
      16: w = {w[28] ? 5'b00001 : {1'b0, w[27], 3'b000}, w[26:15], 3'b010, w[11:7],
               `RV32_AMO_OP};
      default: ;
    endcase
    if ($urandom_range(0, 7) == 0)
      w[11:7] = 5'd0;
    return w;
  endfunction

  // Expected {class, write_rd, read_rs1, read_rs2, unsupported}
  function automatic logic [7:0] model_decode(input instr_t w);
    logic [3:0] cls;
    logic [2:0] regs;
    logic       uns;
    logic [2:0] f3;
    f3   = w[14:12];
    cls  = e_op_none;
    regs = 3'b000;
    uns  = 1'b0;
    case (w[6:0])
      `RV32_LUI_OP, `RV32_AUIPC_OP: {cls, regs} = {e_op_alu, 3'b100};
      `RV32_OP_IMM:  {cls, regs} = {e_op_alu, 3'b110};
      `RV32_LOAD:    {cls, regs} = {e_op_load, 3'b110};
      `RV32_STORE:   {cls, regs} = {e_op_store, 3'b011};
      `RV32_BRANCH:  {cls, regs} = {e_op_branch, 3'b011};
      `RV32_JAL_OP:  {cls, regs} = {e_op_jal, 3'b100};
      `RV32_JALR_OP: {cls, regs} = {e_op_jalr, 3'b110};
      `RV32_OP: begin
        regs = 3'b111;
        if (w[31:25] == 7'b0 || (w[31:25] == 7'b0100000 && f3 inside {3'b000, 3'b101}))
          cls = e_op_alu;
        else if (w ==? `RV32_MUL)
          cls = e_op_mul;
        else if (w ==? `RV32_MULH || w ==? `RV32_MULHSU || w ==? `RV32_MULHU)
          uns = 1'b1;
        else if (w[31:25] == 7'b0000001)
          cls = e_op_div;
      end
      `RV32_MISC_MEM: begin
        if (f3 == 3'b000 && w[31:28] == `RV32_FENCE_FM)
          cls = e_op_fence;
        else if (f3 == 3'b000 && w[31:28] == `RV32_BARSEND_FM)
          cls = e_op_barsend;
        else if (f3 == 3'b000 && w[31:28] == `RV32_BARRECV_FM)
          cls = e_op_barrecv;
      end
      `RV32_SYSTEM: begin
        // Register source only for CSRRW, CSRRS and CSRRC
        regs = {1'b1, f3 inside {3'd1, 3'd2, 3'd3}, 1'b0};
        if (w == `RV32_MRET)
          cls = e_op_mret;
        else if (f3 != 3'b000 && f3 != 3'b100)
          cls = e_op_csr;
      end
      `RV32_AMO_OP: begin
        regs = {2'b11, w[31:27] inside {5'b00000, 5'b00001, 5'b01000}};
        if (w ==? `RV32_LR_W)
          cls = e_op_lr;
        else if (w ==? `RV32_AMOSWAP_W || w ==? `RV32_AMOOR_W || w ==? `RV32_AMOADD_W)
          cls = e_op_amo;
      end
      default: ;
    endcase
    if (w[11:7] == 5'd0)
      regs[2] = 1'b0;
    return {cls, regs, uns};
  endfunction

  task automatic check_value(input string what, input int h, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("error at %0t: hart %0d %s is %0h, expected %0h", $time, h, what, got, want);
    end
  endtask

  task automatic check_output(input int h);
    instr_t     word;
    logic [7:0] want;
    word = exp_mem[exp_pc[h]];
    want = model_decode(word);
    check_value("pc", h, 32'(dec_pc_o[h]), 32'(exp_pc[h]));
    check_value("instr", h, dec_instr_o[h], word);
    check_value("class", h, 32'(dec_class_o[h]), 32'(want[7:4]));
    check_value("write_rd", h, 32'(dec_write_rd_o[h]), 32'(want[3]));
    check_value("read_rs1", h, 32'(dec_read_rs1_o[h]), 32'(want[2]));
    check_value("read_rs2", h, 32'(dec_read_rs2_o[h]), 32'(want[1]));
    check_value("unsupported", h, 32'(dec_unsupported_o[h]), 32'(want[0]));
    // Next PC wraps inside the hart's region
    exp_pc[h] = pc_t'(h * REGION + (int'(exp_pc[h]) + 1) % REGION);
    outstanding[h]++;
    checks++;
    assert (outstanding[h] <= CREDITS) else begin
      errors++;
      $display("error at %0t: hart %0d has %0d outputs unacknowledged", $time, h,
               outstanding[h]);
    end
  endtask

  task automatic wait_outputs(input int n);
    int target [NUM_HARTS];
    for (int h = 0; h < NUM_HARTS; h++)
      target[h] = out_count[h] + n;
    for (int h = 0; h < NUM_HARTS; h++)
      wait (out_count[h] >= target[h]);
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Output checks and credit return, phase 0 random, 1 hart 0 starved, 2 immediate
  always @(posedge clk_i) begin : monitor
    logic give;
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (!rst_n_i || !run_i) begin
        exp_pc[h] = pc_t'(h * REGION);
        if (cycle > 0) begin
          checks++;
          assert (!dec_valid_o[h]) else begin
            errors++;
            $display("error at %0t: hart %0d output while idle", $time, h);
          end
        end
      end else if (dec_valid_o[h]) begin
        if (phase == 2 && c_count[h] > 0) begin
          checks++;
          assert (gap[h] <= MAX_GAP) else begin
            errors++;
            $display("error at %0t: hart %0d went %0d cycles without output", $time, h,
                     gap[h]);
          end
        end
        check_output(h);
        out_count[h]++;
        gap[h] = 0;
        if (phase == 2)
          c_count[h]++;
      end else begin
        gap[h]++;
      end
      give = 1'b0;
      if (outstanding[h] > 0) begin
        case (phase)
          0: give = $urandom_range(0, 99) < 40;
          1: give = (h != 0) && ($urandom_range(0, 99) < 40);
          default: give = 1'b1;
        endcase
      end
      if (give)
        outstanding[h]--;
      credit_i[h] <= give;
    end
    cycle++;
  end

  initial begin : stimulus
    int     quiet_start;
    instr_t word;
    void'($urandom(SEED));
    rst_n_i   = 1'b0;
    run_i     = 1'b0;
    ld_we_i   = 1'b0;
    ld_addr_i = '0;
    ld_data_i = '0;
    phase     = 0;
    checks    = 0;
    errors    = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Memory load while run_i is low
    for (int a = 0; a < DEPTH; a++) begin
      word = random_word();
      exp_mem[a] = word;
      ld_we_i   <= 1'b1;
      ld_addr_i <= pc_t'(a);
      ld_data_i <= word;
      @(posedge clk_i);
    end
    ld_we_i <= 1'b0;
    run_i   <= 1'b1;
    wait_outputs(A_WORDS);
    phase <= 1;
    repeat (STALL_CYCLES / 2) @(posedge clk_i);
    @(negedge clk_i);
    quiet_start = out_count[0];
    repeat (STALL_CYCLES / 2) @(posedge clk_i);
    @(negedge clk_i);
    check_value("outputs while starved", 0, 32'(out_count[0]), 32'(quiet_start));
    check_value("unacknowledged count", 0, 32'(outstanding[0]), 32'(CREDITS));
    // Credits come back at once, hart 0 must resume in order
    phase <= 2;
    wait_outputs(C_WORDS);
    @(posedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Timeout: the harts stopped producing outputs before the tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
logic/vanilla_decode_pkg.sv
logic/imem_if.sv
logic/cl_decode.sv
logic/imem_arbiter.sv
logic/fetch_unit.sv
logic/frontend_top.sv
tb/frontend_asserts.sv
tb/tb_frontend.sv
